// File: Makefile
TOOL  = verilator
FLAGS = --binary --timing -j 0
TOP   = tb_ppu_top
FLIST = ppu_top.f
LOG   = sim.log

.PHONY: all build run lint clean

all: run

build:
	$(TOOL) $(FLAGS) -f $(FLIST) --top-module $(TOP)

run: build
	-./obj_dir/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "TESTS FAILED" $(LOG); then exit 1; fi
	@grep -q "TESTS PASSED" $(LOG)

lint:
	$(TOOL) --lint-only --timing -f $(FLIST) --top-module $(TOP)

clean:
	rm -rf obj_dir $(LOG)

// File: ppu_top.f
verilog/ppu_reg_pkg.sv
verilog/ppu_video_pkg.sv
verilog/ppu_regs.sv
verilog/ppu_timing.sv
verilog/bg_fetcher.sv
verilog/pixel_shifter.sv
verilog/ppu_top.sv
test/tb_ppu_top.sv

// File: test/ppu_trace.txt
# cmd addr data: M fills a VRAM byte, W writes a register, R reads a register and expects data
# L runs the number of lines given in the addr column (hex), data column unused
W ff42 25
R ff42 25
W ff43 0d
R ff43 0d
W ff47 e4
R ff47 e4
W ff41 40
R ff41 c6
R ff4a ff
W ff44 55
R ff44 00
M 9800 00
M 9801 7f
M 9c21 80
M 9c24 ff
W ff42 00
W ff43 00
W ff41 00
W ff45 99
W ff40 91
L 9a 00
R ff44 00
W ff42 25
W ff43 0d
W ff40 89
L 14 00
R ff44 14
W ff40 88
W ff45 18
W ff41 40
L 0a 00
R ff44 1e
W ff40 00
L 03 00
R ff44 00

// File: test/tb_ppu_top.sv
// trace driven testbench; VRAM model covers 8000-9FFF only, timing checks assume one dot per clock
`timescale 1ns/1ps
`default_nettype none

module tb_ppu_top;

    localparam int vram_latency = 2;

    logic        clk;
    logic        rst;
    logic [15:0] addr;
    logic        wr;
    logic        rd;
    logic [7:0]  wr_data;
    logic [7:0]  rd_data;
    logic        vram_rd;
    logic [15:0] vram_addr;
    logic [7:0]  vram_data;
    logic        px_valid;
    logic [1:0]  px_color;
    logic        irq_vblank;
    logic        irq_stat;

    logic [7:0]  mem [0:8191];  // 8000-9FFF
    logic [7:0]  cmd_q [$];
    logic [15:0] arg_a [$];
    logic [7:0]  arg_b [$];
    int          cycle;
    int          limit;
    bit          ref_on;
    bit          watch_stat;
    int          ref_dot;
    int          ref_line;
    int          px_count;
    int          pend_cnt;
    logic [15:0] pend_addr;
    logic [7:0]  lcdc_ref;
    logic [7:0]  scx_ref;
    logic [7:0]  scy_ref;
    logic [7:0]  lyc_ref;
    logic [7:0]  stat_ref;

    ppu_top #(.vram_latency(vram_latency)) u_dut (
        .clk(clk), .rst(rst), .addr(addr), .wr(wr), .rd(rd), .wr_data(wr_data),
        .rd_data(rd_data), .vram_rd(vram_rd), .vram_addr(vram_addr), .vram_data(vram_data),
        .px_valid(px_valid), .px_color(px_color), .irq_vblank(irq_vblank), .irq_stat(irq_stat)
    );

    always #5 clk = ~clk;

    task automatic check(input string name, input int expected, input int actual);
        if (expected != actual) begin
            $display("CHECK FAILED %s expected %0h actual %0h", name, expected, actual);
            $display("TESTS FAILED");
            $fatal(1, "value mismatch");
        end
    endtask

    task automatic abort_run(input string what);
        $display("%s", what);
        $display("TESTS FAILED");
        $fatal(1, "run aborted");
    endtask

    // one clock, then inputs settle 1 ns after the edge
    task automatic tick();
        @(posedge clk);
        cycle = cycle + 1;
        if (cycle > limit)
            abort_run("run exceeded its cycle limit, the DUT stopped making progress");
        if (ref_on) begin
            if (ref_dot == 455) begin
                ref_dot  = 0;
                ref_line = (ref_line == 153) ? 0 : ref_line + 1;
            end else begin
                ref_dot = ref_dot + 1;
            end
        end
        #1;
    endtask

    task automatic reg_write(input logic [15:0] a, input logic [7:0] d);
        addr    = a;
        wr_data = d;
        wr      = 1'b1;
        tick();
        wr = 1'b0;
        case (a)
            16'hff40: begin
                if (d[7] && !ref_on) begin
                    ref_on   = 1'b1;  // dot 0 of line 0 starts now
                    ref_dot  = 0;
                    ref_line = 0;
                end else if (!d[7]) begin
                    ref_on = 1'b0;
                end
                lcdc_ref = d;
            end
            16'hff41: stat_ref = d;
            16'hff42: scy_ref  = d;
            16'hff43: scx_ref  = d;
            16'hff45: lyc_ref  = d;
            default: ;
        endcase
    endtask

    task automatic reg_read(input logic [15:0] a, input logic [7:0] expected);
        addr = a;
        rd   = 1'b1;
        @(negedge clk);
        check($sformatf("read %h", a), int'(expected), int'(rd_data));
        tick();
        rd = 1'b0;
    endtask

    // runs to dot 0 of a later line, STAT stays on the read port for the monitor
    task automatic run_lines(input int n);
        int passed;
        passed = 0;
        if (!ref_on) begin
            repeat (n * 456) tick();
        end else begin
            addr       = 16'hff41;
            rd         = 1'b1;
            watch_stat = 1'b1;
            while (passed < n) begin
                tick();
                if (ref_dot == 0)
                    passed = passed + 1;
            end
            watch_stat = 1'b0;
            rd         = 1'b0;
        end
    endtask

    function automatic logic [1:0] bg_color(input int y, input int x);
        logic [7:0]  yy;
        logic [7:0]  sx;
        logic [7:0]  tile;
        logic [15:0] map_a;
        logic [15:0] row_a;
        logic [15:0] row_b;
        int          bitpos;
        if (!lcdc_ref[0])
            return 2'b00;
        yy    = 8'(y) + scy_ref;
        sx    = 8'(x) + scx_ref;
        map_a = (lcdc_ref[3] ? 16'h9c00 : 16'h9800) + 16'(yy[7:3]) * 16'd32 + 16'(sx[7:3]);
        tile  = mem[map_a[12:0]];
        if (lcdc_ref[4])
            row_a = 16'h8000 + 16'(tile) * 16'd16;
        else
            row_a = 16'h9000 + 16'(int'($signed(tile)) * 16);  // signed tile number
        row_a  = row_a + 16'(yy[2:0]) * 16'd2;
        row_b  = row_a + 16'd1;
        bitpos = 7 - int'(sx[2:0]);  // msb is leftmost
        return {mem[row_b[12:0]][bitpos], mem[row_a[12:0]][bitpos]};
    endfunction

    // VRAM answers vram_latency edges after the request
    always @(posedge clk) begin
        if (vram_rd) begin
            check("VRAM address in 8000-9FFF", 4, int'(vram_addr[15:13]));
            pend_addr = vram_addr;
            pend_cnt  = vram_latency;
        end
        if (pend_cnt > 0) begin
            pend_cnt = pend_cnt - 1;
            if (pend_cnt == 0) begin
                #1 vram_data = mem[pend_addr[12:0]];
            end
        end
    end

    always @(negedge clk) begin
        int         drawn;
        logic [1:0] exp_md;
        logic       exp_co;
        logic       exp_irq;
        if (!ref_on) begin
            if (vram_rd || px_valid || irq_stat)
                abort_run("VRAM read, pixel or STAT interrupt seen while the display is off");
        end else begin
            if (ref_dot == 0)
                px_count = 0;
            drawn = px_count;  // pixels before this cycle
            if (px_valid) begin
                check("pixel colour", int'(bg_color(ref_line, px_count)), int'(px_color));
                px_count = px_count + 1;
            end
            if (ref_line < 144 && ref_dot == 455)
                check("pixels per line", 160, px_count);
            if (watch_stat) begin
                if (ref_line >= 144)
                    exp_md = 2'd1;
                else if (ref_dot < 80)
                    exp_md = 2'd2;
                else if (drawn < 160)
                    exp_md = 2'd3;  // draw lasts until the cycle after the last pixel
                else
                    exp_md = 2'd0;
                exp_co  = (ref_line == int'(lyc_ref));
                exp_irq = (exp_co && stat_ref[6]) || (exp_md == 2'd2 && stat_ref[5]) ||
                          (exp_md == 2'd1 && stat_ref[4]) || (exp_md == 2'd0 && stat_ref[3]);
                check("STAT mode", int'(exp_md), int'(rd_data[1:0]));
                check("LY=LYC flag", int'(exp_co), int'(rd_data[2]));
                check("irq_vblank", int'(ref_line >= 144), int'(irq_vblank));
                check("irq_stat", int'(exp_irq), int'(irq_stat));
            end
        end
    end

    initial begin
        int    fd;
        int    n;
        int    total;
        string line;
        logic [7:0]  c;
        logic [15:0] a;
        logic [7:0]  b;
        clk = 1'b0;
        rst = 1'b1;
        wr = 1'b0;
        rd = 1'b0;
        addr = 16'h0000;
        wr_data = 8'h00;
        vram_data = 8'h00;
        ref_on = 1'b0;
        watch_stat = 1'b0;
        ref_dot = 0;
        ref_line = 0;
        px_count = 0;
        pend_cnt = 0;
        pend_addr = 16'h0000;
        lcdc_ref = 8'h00;
        scx_ref = 8'h00;
        scy_ref = 8'h00;
        lyc_ref = 8'h00;
        stat_ref = 8'h00;
        cycle = 0;
        total = 0;
        void'($urandom(32'he80b_29b5));
        for (int i = 0; i < 8192; i++) begin
            if (i < 32'h1800)
                mem[i] = 8'($urandom);  // tile data
            else
                mem[i] = 8'(i ^ (i >> 5) ^ 32'h3c);  // tile map
        end
        fd = $fopen("test/ppu_trace.txt", "r");
        if (fd == 0)
            abort_run("trace file test/ppu_trace.txt could not be opened");
        while (!$feof(fd)) begin
            n = $fgets(line, fd);
            if (n > 1 && line[0] != 8'h23) begin
                n = $sscanf(line, "%c %h %h", c, a, b);
                if (n >= 2) begin
                    cmd_q.push_back(c);
                    arg_a.push_back(a);
                    arg_b.push_back(b);
                    if (c == "L")
                        total = total + int'(a);
                end
            end
        end
        $fclose(fd);
        limit = total * 456 + 2000;
        repeat (8) tick();
        rst = 1'b0;
        foreach (cmd_q[i]) begin
            case (cmd_q[i])
                "M": mem[arg_a[i][12:0]] = arg_b[i];
                "W": reg_write(arg_a[i], arg_b[i]);
                "R": reg_read(arg_a[i], arg_b[i]);
                "L": run_lines(int'(arg_a[i]));
                default: abort_run("unknown command in trace file");
            endcase
        end
        $display("TESTS PASSED");
        $finish;
    end

endmodule

`default_nettype wire

// File: verilog/bg_fetcher.sv
// background fetcher; reads map entry, low and high row per tile, one request in flight at a time
`timescale 1ns/1ps
`default_nettype none

module bg_fetcher #(
    parameter int vram_latency = 2  // 1 to 4 cycles from vram_rd to vram_data
) (
    input  logic        clk,
    input  logic        rst,
    input  logic [7:0]  lcdc,
    input  logic [7:0]  scx,
    input  logic [7:0]  scy,
    input  logic [7:0]  ly,
    input  logic        line_start,
    input  logic        line_done,
    input  logic        row_take,
    input  logic [7:0]  vram_data,
    output logic        vram_rd,
    output logic [15:0] vram_addr,
    output logic [7:0]  row_lo,
    output logic [7:0]  row_hi,
    output logic        row_full
);

    typedef enum logic [1:0] {
        ph_map = 2'd0,
        ph_lo  = 2'd1,
        ph_hi  = 2'd2
    } phase_t;

    phase_t      phase;      // read in flight or next to issue
    logic        active;
    logic        pending;
    logic [2:0]  wait_cnt;
    logic [4:0]  col;        // tile column within the line
    logic        go;
    logic        sample_now;
    logic        issue_map;
    logic [7:0]  y_sum;
    logic [4:0]  x_tile;
    logic [15:0] map_addr;
    logic [15:0] tile_base;
    logic [15:0] tile_off;
    logic [15:0] lo_addr;
    logic [7:0]  row_data;

    assign y_sum  = ly + scy;
    assign x_tile = scx[7:3] + col;  // wraps at 32 tiles

    assign map_addr = (lcdc[ppu_reg_pkg::lcdc_map_sel] ? ppu_video_pkg::map_base_1 :
                       ppu_video_pkg::map_base_0) + {6'd0, y_sum[7:3], x_tile};

    // tile number arrives on vram_data in the map sample cycle
    assign tile_base = lcdc[ppu_reg_pkg::lcdc_tile_sel] ? ppu_video_pkg::tile_base_unsigned :
                       ppu_video_pkg::tile_base_signed;
    assign tile_off  = lcdc[ppu_reg_pkg::lcdc_tile_sel] ? {4'd0, vram_data, 4'd0} :
                       {{4{vram_data[7]}}, vram_data, 4'd0};
    assign lo_addr   = tile_base + tile_off + {12'd0, y_sum[2:0], 1'b0};

    assign row_data   = lcdc[ppu_reg_pkg::lcdc_bg_enable] ? vram_data : 8'h00;
    assign go         = active && !line_done;
    assign sample_now = pending && (wait_cnt == 3'd0);
    // next tile may start in the cycle the shifter takes the row
    assign issue_map  = go && !pending && (phase == ph_map) && (!row_full || row_take);

    always_ff @(posedge clk) begin
        vram_rd <= 1'b0;
        if (rst || !lcdc[ppu_reg_pkg::lcdc_enable]) begin
            active   <= 1'b0;
            pending  <= 1'b0;
            wait_cnt <= 3'd0;
            phase    <= ph_map;
            col      <= 5'd0;
            row_full <= 1'b0;
        end else begin
            if (row_take)
                row_full <= 1'b0;
            if (line_start) begin
                active   <= 1'b1;
                phase    <= ph_map;
                col      <= 5'd0;
                row_full <= 1'b0;  // leftover from last line
            end else if (line_done) begin
                active <= 1'b0;
            end

            if (pending && wait_cnt != 3'd0)
                wait_cnt <= wait_cnt - 3'd1;

            if (sample_now) begin
                pending <= 1'b0;
                case (phase)
                    ph_map: begin
                        phase <= ph_lo;
                        if (go) begin
                            vram_rd   <= 1'b1;
                            vram_addr <= lo_addr;
                            pending   <= 1'b1;
                            wait_cnt  <= 3'(vram_latency);
                        end
                    end
                    ph_lo: begin
                        row_lo <= row_data;
                        phase  <= ph_hi;
                        if (go) begin
                            vram_rd   <= 1'b1;
                            vram_addr <= vram_addr + 16'd1;  // high byte follows low
                            pending   <= 1'b1;
                            wait_cnt  <= 3'(vram_latency);
                        end
                    end
                    default: begin
                        row_hi   <= row_data;
                        row_full <= active;
                        phase    <= ph_map;
                        col      <= col + 5'd1;
                    end
                endcase
            end else if (issue_map) begin
                vram_rd   <= 1'b1;
                vram_addr <= map_addr;
                pending   <= 1'b1;
                wait_cnt  <= 3'(vram_latency);
            end
        end
    end

    // the memory sees no second request until the data was sampled
    a_one_outstanding: assert property (@(posedge clk) disable iff (rst)
        vram_rd |=> !vram_rd [*vram_latency]);

endmodule

`default_nettype wire

// File: verilog/pixel_shifter.sv
// background pixel shifter; emits raw 2-bit colour indices, palette is not applied
`timescale 1ns/1ps
`default_nettype none

module pixel_shifter (
    input  logic       clk,
    input  logic       rst,
    input  logic [7:0] scx,
    input  logic       line_start,
    input  logic [7:0] row_lo,
    input  logic [7:0] row_hi,
    input  logic       row_full,
    output logic       row_take,
    output logic       px_valid,
    output logic [1:0] px_color,
    output logic       line_done
);

    logic       active;
    logic [7:0] sh_lo;
    logic [7:0] sh_hi;
    logic [3:0] sh_cnt;    // pixels still held
    logic [2:0] drop_cnt;  // fine scroll pixels left to discard
    logic [7:0] px_cnt;
    logic       holding;

    assign holding   = (sh_cnt != 4'd0);
    assign row_take  = active && !holding && row_full;
    assign px_valid  = active && holding && (drop_cnt == 3'd0);
    assign px_color  = {sh_hi[7], sh_lo[7]};  // msb is leftmost pixel
    assign line_done = px_valid && (px_cnt == 8'(ppu_video_pkg::line_pixels - 1));

    always_ff @(posedge clk) begin
        if (rst) begin
            active   <= 1'b0;
            sh_cnt   <= 4'd0;
            drop_cnt <= 3'd0;
            px_cnt   <= 8'd0;
        end else if (line_start) begin
            active   <= 1'b1;
            sh_cnt   <= 4'd0;
            drop_cnt <= scx[2:0];
            px_cnt   <= 8'd0;
        end else if (active) begin
            if (row_take) begin
                sh_lo  <= row_lo;
                sh_hi  <= row_hi;
                sh_cnt <= 4'd8;
            end else if (holding) begin
                sh_lo  <= {sh_lo[6:0], 1'b0};
                sh_hi  <= {sh_hi[6:0], 1'b0};
                sh_cnt <= sh_cnt - 4'd1;
                if (drop_cnt != 3'd0)
                    drop_cnt <= drop_cnt - 3'd1;
                else
                    px_cnt <= px_cnt + 8'd1;
            end
            if (line_done)
                active <= 1'b0;
        end
    end

    // a loaded row is fully shifted out before the next load
    a_no_load_holding: assert property (@(posedge clk) disable iff (rst)
        row_take |=> !row_take [*8]);

endmodule

`default_nettype wire

// File: verilog/ppu_reg_pkg.sv
// LCD register map and bit positions; OBP0, OBP1, WX, WY and DMA are not mapped and read as FF
`default_nettype none

package ppu_reg_pkg;

    // CPU visible register addresses
    localparam logic [15:0] addr_lcdc = 16'hff40;
    localparam logic [15:0] addr_stat = 16'hff41;
    localparam logic [15:0] addr_scy  = 16'hff42;
    localparam logic [15:0] addr_scx  = 16'hff43;
    localparam logic [15:0] addr_ly   = 16'hff44;  // read only
    localparam logic [15:0] addr_lyc  = 16'hff45;
    localparam logic [15:0] addr_bgp  = 16'hff47;  // stored, never applied to pixels

    // LCDC bits
    localparam int lcdc_enable    = 7;  // display on
    localparam int lcdc_tile_sel  = 4;  // 1: unsigned tiles at 8000
    localparam int lcdc_map_sel   = 3;  // 1: map at 9c00
    localparam int lcdc_bg_enable = 0;

    // STAT interrupt enables
    localparam int stat_coinc_irq_en  = 6;
    localparam int stat_oam_irq_en    = 5;
    localparam int stat_vblank_irq_en = 4;
    localparam int stat_hblank_irq_en = 3;

    localparam logic [7:0] unmapped_read = 8'hff;  // open bus value

endpackage

`default_nettype wire

// File: verilog/ppu_regs.sv
// LCD register file; rd_data is combinational and reads FF when rd is low or the address is unmapped
`timescale 1ns/1ps
`default_nettype none

module ppu_regs (
    input  logic                     clk,
    input  logic                     rst,
    input  logic [15:0]              addr,
    input  logic                     wr,
    input  logic                     rd,
    input  logic [7:0]               wr_data,
    input  logic [7:0]               ly,
    input  ppu_video_pkg::lcd_mode_t mode,
    output logic [7:0]               rd_data,
    output logic [7:0]               lcdc,
    output logic [7:0]               scx,
    output logic [7:0]               scy,
    output logic                     irq_vblank,
    output logic                     irq_stat
);

    logic [6:3] stat_en;  // writable part of STAT
    logic [7:0] lyc;
    logic [7:0] bgp;
    logic       coinc;
    logic [7:0] stat;

    assign coinc = (ly == lyc);
    assign stat  = {1'b1, stat_en, coinc, mode};  // bit 7 always reads set

    always_ff @(posedge clk) begin
        if (rst) begin
            lcdc    <= 8'h00;
            stat_en <= 4'h0;
            scy     <= 8'h00;
            scx     <= 8'h00;
            lyc     <= 8'h00;
            bgp     <= 8'h00;
        end else if (wr) begin
            case (addr)
                ppu_reg_pkg::addr_lcdc: lcdc    <= wr_data;
                ppu_reg_pkg::addr_stat: stat_en <= wr_data[6:3];  // flags and mode stay live
                ppu_reg_pkg::addr_scy:  scy     <= wr_data;
                ppu_reg_pkg::addr_scx:  scx     <= wr_data;
                ppu_reg_pkg::addr_lyc:  lyc     <= wr_data;
                ppu_reg_pkg::addr_bgp:  bgp     <= wr_data;
                default: ;  // LY and unmapped writes dropped
            endcase
        end
    end

    always_comb begin
        rd_data = ppu_reg_pkg::unmapped_read;
        if (rd) begin
            case (addr)
                ppu_reg_pkg::addr_lcdc: rd_data = lcdc;
                ppu_reg_pkg::addr_stat: rd_data = stat;
                ppu_reg_pkg::addr_scy:  rd_data = scy;
                ppu_reg_pkg::addr_scx:  rd_data = scx;
                ppu_reg_pkg::addr_ly:   rd_data = ly;
                ppu_reg_pkg::addr_lyc:  rd_data = lyc;
                ppu_reg_pkg::addr_bgp:  rd_data = bgp;
                default:                rd_data = ppu_reg_pkg::unmapped_read;
            endcase
        end
    end

    assign irq_vblank = (mode == ppu_video_pkg::mode_vblank);

    // STAT line, quiet while the display is off
    assign irq_stat = lcdc[ppu_reg_pkg::lcdc_enable] && (
        (coinc && stat_en[ppu_reg_pkg::stat_coinc_irq_en]) ||
        (mode == ppu_video_pkg::mode_oam_scan && stat_en[ppu_reg_pkg::stat_oam_irq_en]) ||
        (mode == ppu_video_pkg::mode_vblank && stat_en[ppu_reg_pkg::stat_vblank_irq_en]) ||
        (mode == ppu_video_pkg::mode_hblank && stat_en[ppu_reg_pkg::stat_hblank_irq_en]));

    // the CPU bus never reads and writes in one cycle
    a_no_rd_wr: assert property (@(posedge clk) disable iff (rst) !(wr && rd));

endmodule

`default_nettype wire

// File: verilog/ppu_timing.sv
// dot and line counters; dots advance every clock, draw length is set by line_done from the shifter
`timescale 1ns/1ps
`default_nettype none

module ppu_timing (
    input  logic                     clk,
    input  logic                     rst,
    input  logic [7:0]               lcdc,
    input  logic                     line_done,
    output logic [7:0]               ly,
    output ppu_video_pkg::lcd_mode_t mode,
    output logic                     line_start
);

    logic [8:0] dot;
    logic       lcd_on;
    logic       last_dot;

    assign lcd_on   = lcdc[ppu_reg_pkg::lcdc_enable];
    assign last_dot = (dot == 9'(ppu_video_pkg::dots_per_line - 1));

    always_ff @(posedge clk) begin
        if (rst || !lcd_on) begin
            dot        <= 9'd0;
            ly         <= 8'd0;
            mode       <= ppu_video_pkg::mode_oam_scan;
            line_start <= 1'b0;
        end else begin
            line_start <= 1'b0;
            if (last_dot) begin
                dot <= 9'd0;
                if (ly == 8'(ppu_video_pkg::lines_per_frame - 1)) begin
                    ly   <= 8'd0;  // frame wrap
                    mode <= ppu_video_pkg::mode_oam_scan;
                end else begin
                    ly   <= ly + 8'd1;
                    mode <= (ly < 8'(ppu_video_pkg::visible_lines - 1)) ?
                            ppu_video_pkg::mode_oam_scan : ppu_video_pkg::mode_vblank;
                end
            end else begin
                dot <= dot + 9'd1;
                case (mode)
                    ppu_video_pkg::mode_oam_scan: begin
                        if (dot == 9'(ppu_video_pkg::scan_dots - 1)) begin
                            mode       <= ppu_video_pkg::mode_draw;
                            line_start <= 1'b1;  // high during dot 80
                        end
                    end
                    ppu_video_pkg::mode_draw: begin
                        if (line_done)
                            mode <= ppu_video_pkg::mode_hblank;
                    end
                    default: ;  // hblank and vblank run to the end of line
                endcase
            end
        end
    end

    // the shifter finishes only while drawing
    a_done_in_draw: assert property (@(posedge clk) disable iff (rst || !lcd_on)
        line_done |-> mode == ppu_video_pkg::mode_draw);

    // fetch and shift must finish before the line ends
    a_draw_fits: assert property (@(posedge clk) disable iff (rst || !lcd_on)
        mode == ppu_video_pkg::mode_draw |-> !last_dot);

endmodule

`default_nettype wire

// File: verilog/ppu_top.sv
// background-only PPU; no sprites, window or DMA, pixels leave as raw colour indices
`timescale 1ns/1ps
`default_nettype none

module ppu_top #(
    parameter int vram_latency = 2  // cycles from vram_rd to vram_data
) (
    input  logic        clk,
    input  logic        rst,
    input  logic [15:0] addr,
    input  logic        wr,
    input  logic        rd,
    input  logic [7:0]  wr_data,
    output logic [7:0]  rd_data,
    output logic        vram_rd,
    output logic [15:0] vram_addr,
    input  logic [7:0]  vram_data,
    output logic        px_valid,
    output logic [1:0]  px_color,
    output logic        irq_vblank,
    output logic        irq_stat
);

    logic [7:0]               lcdc;
    logic [7:0]               scx;
    logic [7:0]               scy;
    logic [7:0]               ly;
    ppu_video_pkg::lcd_mode_t mode;
    logic                     line_start;
    logic                     line_done;
    logic [7:0]               row_lo;
    logic [7:0]               row_hi;
    logic                     row_full;
    logic                     row_take;

    ppu_regs u_regs (
        .clk        (clk),
        .rst        (rst),
        .addr       (addr),
        .wr         (wr),
        .rd         (rd),
        .wr_data    (wr_data),
        .ly         (ly),
        .mode       (mode),
        .rd_data    (rd_data),
        .lcdc       (lcdc),
        .scx        (scx),
        .scy        (scy),
        .irq_vblank (irq_vblank),
        .irq_stat   (irq_stat)
    );

    ppu_timing u_timing (
        .clk        (clk),
        .rst        (rst),
        .lcdc       (lcdc),
        .line_done  (line_done),
        .ly         (ly),
        .mode       (mode),
        .line_start (line_start)
    );

    bg_fetcher #(
        .vram_latency (vram_latency)
    ) u_fetcher (
        .clk        (clk),
        .rst        (rst),
        .lcdc       (lcdc),
        .scx        (scx),
        .scy        (scy),
        .ly         (ly),
        .line_start (line_start),
        .line_done  (line_done),
        .row_take   (row_take),
        .vram_data  (vram_data),
        .vram_rd    (vram_rd),
        .vram_addr  (vram_addr),
        .row_lo     (row_lo),
        .row_hi     (row_hi),
        .row_full   (row_full)
    );

    pixel_shifter u_shifter (
        .clk        (clk),
        .rst        (rst || !lcdc[ppu_reg_pkg::lcdc_enable]),  // held clear with the display off
        .scx        (scx),
        .line_start (line_start),
        .row_lo     (row_lo),
        .row_hi     (row_hi),
        .row_full   (row_full),
        .row_take   (row_take),
        .px_valid   (px_valid),
        .px_color   (px_color),
        .line_done  (line_done)
    );

endmodule

`default_nettype wire

// File: verilog/ppu_video_pkg.sv
// line and frame timing of the LCD plus VRAM region bases; mode encoding matches STAT bits 1:0
`default_nettype none

package ppu_video_pkg;

    typedef enum logic [1:0] {
        mode_hblank   = 2'd0,
        mode_vblank   = 2'd1,
        mode_oam_scan = 2'd2,
        mode_draw     = 2'd3
    } lcd_mode_t;

    // one dot per clock
    localparam int dots_per_line   = 456;
    localparam int scan_dots       = 80;
    localparam int visible_lines   = 144;
    localparam int lines_per_frame = 154;
    localparam int line_pixels     = 160;

    // background maps, 32x32 tile entries each
    localparam logic [15:0] map_base_0 = 16'h9800;
    localparam logic [15:0] map_base_1 = 16'h9c00;

    // tile data, 16 bytes per tile
    localparam logic [15:0] tile_base_unsigned = 16'h8000;
    localparam logic [15:0] tile_base_signed   = 16'h9000;  // tile number -128..127 around it

endpackage

`default_nettype wire
